// ==== common/mips_pkg.sv ====
package mips_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 1 << reg_addr_w;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    ////////////////////////////////////////
    // Opcode field, instr[31:26]
    ////////////////////////////////////////

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // Function field of R-type, instr[5:0]
    localparam logic [5:0] funct_addu = 6'h21;
    localparam logic [5:0] funct_subu = 6'h23;
    localparam logic [5:0] funct_and  = 6'h24;
    localparam logic [5:0] funct_or   = 6'h25;
    localparam logic [5:0] funct_xor  = 6'h26;
    localparam logic [5:0] funct_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_t;

    // Decoded control, carried from decode down to memory
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    branch;
        logic    branch_ne;
        alu_op_t alu_op;
    } ctrl_t;

    localparam ctrl_t ctrl_nop  = '0;
    localparam word_t nop_instr = '0;

endpackage

// ==== src/execute/alu.sv ====
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero
);

    always_comb begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {{(data_w-1){1'b0}}, $signed(a) < $signed(b)};
            // Upper immediate already shifted in decode
            alu_lui: result = b;
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== src/decode/decoder.sv ====
`timescale 1ns/1ps

module decoder import mips_pkg::*; (
    input  word_t     instr,
    output ctrl_t     ctrl,
    output reg_addr_t rs,
    output reg_addr_t rt,
    output reg_addr_t rd_dest,
    output word_t     imm_ext
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    reg_addr_t   rt_field;
    reg_addr_t   rd_field;
    logic        reads_rt;
    logic        dest_is_rd;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign imm      = instr[15:0];
    assign rt_field = instr[20:16];
    assign rd_field = instr[15:11];
    assign rs       = instr[25:21];

    // rt only reported when it is a source, so load-use checks stay exact
    assign rt      = reads_rt ? rt_field : '0;
    assign rd_dest = !ctrl.reg_write ? '0 : (dest_is_rd ? rd_field : rt_field);

    always_comb begin
        ctrl       = ctrl_nop;
        reads_rt   = 1'b0;
        dest_is_rd = 1'b0;
        imm_ext    = {{16{imm[15]}}, imm};
        case (opcode)
            op_rtype: begin
                reads_rt       = 1'b1;
                dest_is_rd     = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    funct_addu: ctrl.alu_op = alu_add;
                    funct_subu: ctrl.alu_op = alu_sub;
                    funct_and:  ctrl.alu_op = alu_and;
                    funct_or:   ctrl.alu_op = alu_or;
                    funct_xor:  ctrl.alu_op = alu_xor;
                    funct_slt:  ctrl.alu_op = alu_slt;
                    default: begin
                        // Includes the all-zero nop
                        ctrl.reg_write = 1'b0;
                        reads_rt       = 1'b0;
                    end
                endcase
            end
            op_addiu: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_add;
            end
            op_slti: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_slt;
            end
            op_ori: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_or;
                imm_ext          = {16'h0000, imm};
            end
            op_lui: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_lui;
                imm_ext          = {imm, 16'h0000};
            end
            op_lw: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_add;
            end
            op_sw: begin
                reads_rt         = 1'b1;
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_add;
            end
            op_beq, op_bne: begin
                reads_rt       = 1'b1;
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == op_bne);
                ctrl.alu_op    = alu_sub;
            end
            default: begin
                ctrl = ctrl_nop;
            end
        endcase
    end

endmodule

// ==== src/decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    output word_t     rs_data,
    output word_t     rt_data,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [reg_count];

    // Register zero reads zero, a same-cycle write passes straight through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && addr == wr_addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs_data = read_port(rs);
        rt_data = read_port(rt);
    end

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  flush,
    input  logic  branch_taken,
    input  word_t branch_target,
    output word_t imem_addr,
    input  word_t imem_rdata,
    output word_t id_instr,
    output word_t id_pc_4
);

    word_t pc;
    word_t pc_4;

    assign pc_4      = pc + 32'd4;
    // Memory is addressed in words
    assign imem_addr = {2'b00, pc[data_w-1:2]};

    // Program counter, a taken branch wins over a hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (branch_taken) begin
            pc <= branch_target;
        end else if (!stall) begin
            pc <= pc_4;
        end
    end

    // Fetch-to-decode register
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            id_instr <= nop_instr;
        end else if (!stall) begin
            id_instr <= imem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            id_pc_4 <= pc_4;
        end
    end

endmodule

// ==== src/execute/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      flush,
    input  ctrl_t     id_ctrl,
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  reg_addr_t id_rd,
    input  word_t     id_rs_data,
    input  word_t     id_rt_data,
    input  word_t     id_imm,
    input  word_t     id_pc_4,
    input  logic      mem_fwd_we,
    input  reg_addr_t mem_fwd_rd,
    input  word_t     mem_fwd_data,
    input  logic      wb_fwd_we,
    input  reg_addr_t wb_fwd_rd,
    input  word_t     wb_fwd_data,
    output ctrl_t     ex_ctrl,
    output reg_addr_t ex_rs,
    output reg_addr_t ex_rt,
    output reg_addr_t ex_rd,
    output word_t     ex_result,
    output word_t     ex_store_data,
    output logic      branch_taken,
    output word_t     branch_target
);

    word_t e_rs_data;
    word_t e_rt_data;
    word_t e_imm;
    word_t e_pc_4;
    word_t fwd_a;
    word_t fwd_b;
    word_t alu_b;
    logic  alu_zero;

    // Newest producer wins, register zero is never forwarded
    function automatic word_t forward(reg_addr_t src, word_t reg_val);
        if (src == '0) begin
            return reg_val;
        end else if (mem_fwd_we && mem_fwd_rd == src) begin
            return mem_fwd_data;
        end else if (wb_fwd_we && wb_fwd_rd == src) begin
            return wb_fwd_data;
        end
        return reg_val;
    endfunction

    ////////////////////////////////////////
    // Decode-to-execute register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ex_ctrl <= ctrl_nop;
        end else begin
            ex_ctrl <= id_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs     <= id_rs;
        ex_rt     <= id_rt;
        ex_rd     <= id_rd;
        e_rs_data <= id_rs_data;
        e_rt_data <= id_rt_data;
        e_imm     <= id_imm;
        e_pc_4    <= id_pc_4;
    end

    ////////////////////////////////////////
    // Operands and ALU
    ////////////////////////////////////////

    always_comb begin
        fwd_a = forward(ex_rs, e_rs_data);
        fwd_b = forward(ex_rt, e_rt_data);
    end

    assign alu_b         = ex_ctrl.alu_src_imm ? e_imm : fwd_b;
    assign ex_store_data = fwd_b;

    alu u_alu (
        .a      ( fwd_a          ),
        .b      ( alu_b          ),
        .op     ( ex_ctrl.alu_op ),
        .result ( ex_result      ),
        .zero   ( alu_zero       )
    );

    // BEQ takes on equal, BNE on not equal
    assign branch_taken  = ex_ctrl.branch && (alu_zero != ex_ctrl.branch_ne);
    assign branch_target = e_pc_4 + {e_imm[data_w-3:0], 2'b00};

endmodule

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  ctrl_t     ex_ctrl,
    input  reg_addr_t ex_rd,
    input  word_t     ex_result,
    input  word_t     ex_store_data,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    output logic      dmem_re,
    input  word_t     dmem_rdata,
    output logic      mem_fwd_we,
    output reg_addr_t mem_fwd_rd,
    output word_t     mem_fwd_data,
    output logic      wb_we,
    output reg_addr_t wb_rd,
    output word_t     wb_data
);

    ctrl_t     m_ctrl;
    reg_addr_t m_rd;
    word_t     m_result;
    word_t     m_store_data;
    word_t     m_wb_data;

    // Execute-to-memory register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_ctrl <= ctrl_nop;
        end else begin
            m_ctrl <= ex_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        m_rd         <= ex_rd;
        m_result     <= ex_result;
        m_store_data <= ex_store_data;
    end

    assign dmem_addr  = {2'b00, m_result[data_w-1:2]};
    assign dmem_wdata = m_store_data;
    assign dmem_we    = m_ctrl.mem_write;
    assign dmem_re    = m_ctrl.mem_read;

    // Load data is not ready for forwarding until writeback
    assign mem_fwd_we   = m_ctrl.reg_write && !m_ctrl.mem_read;
    assign mem_fwd_rd   = m_rd;
    assign mem_fwd_data = m_result;

    assign m_wb_data = m_ctrl.mem_read ? dmem_rdata : m_result;

    // Memory-to-writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= m_ctrl.reg_write && (m_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= m_rd;
        wb_data <= m_wb_data;
    end

endmodule

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit import mips_pkg::*; (
    input  logic      ex_mem_read,
    input  reg_addr_t ex_rd,
    input  reg_addr_t id_rs,
    input  reg_addr_t id_rt,
    input  logic      branch_taken,
    output logic      stall,
    output logic      bubble,
    output logic      flush
);

    logic load_use;

    // Load in execute feeding the instruction in decode
    assign load_use = ex_mem_read && (ex_rd != '0) &&
                      ((ex_rd == id_rs) || (ex_rd == id_rt));

    // Branch flush overrides the load-use hold
    assign flush  = branch_taken;
    assign stall  = load_use && !branch_taken;

    // Nop into decode-to-execute for either cause
    assign bubble = load_use || branch_taken;

endmodule

// ==== src/mips_core.sv ====
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    output word_t     imem_addr,
    input  word_t     imem_rdata,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    output logic      dmem_re,
    input  word_t     dmem_rdata,
    output logic      trace_valid,
    output reg_addr_t trace_rd,
    output word_t     trace_data
);

    ////////////////////////////////////////
    // Inter-stage wires
    ////////////////////////////////////////

    // Fetch to decode
    word_t     id_instr;
    word_t     id_pc_4;

    // Decode outputs
    ctrl_t     id_ctrl;
    reg_addr_t id_rs;
    reg_addr_t id_rt;
    reg_addr_t id_rd;
    word_t     id_rs_data;
    word_t     id_rt_data;
    word_t     id_imm;

    // Execute outputs
    ctrl_t     ex_ctrl;
    reg_addr_t ex_rd;
    word_t     ex_result;
    word_t     ex_store_data;
    logic      branch_taken;
    word_t     branch_target;

    // Memory and writeback results
    logic      mem_fwd_we;
    reg_addr_t mem_fwd_rd;
    word_t     mem_fwd_data;
    logic      wb_we;
    reg_addr_t wb_rd;
    word_t     wb_data;

    // Hazard controls
    logic      stall;
    logic      bubble;
    logic      flush;

    fetch_stage u_fetch_stage (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .stall         ( stall         ),
        .flush         ( flush         ),
        .branch_taken  ( branch_taken  ),
        .branch_target ( branch_target ),
        .imem_addr     ( imem_addr     ),
        .imem_rdata    ( imem_rdata    ),
        .id_instr      ( id_instr      ),
        .id_pc_4       ( id_pc_4       )
    );

    decoder u_decoder (
        .instr   ( id_instr ),
        .ctrl    ( id_ctrl  ),
        .rs      ( id_rs    ),
        .rt      ( id_rt    ),
        .rd_dest ( id_rd    ),
        .imm_ext ( id_imm   )
    );

    reg_file u_reg_file (
        .clk     ( clk        ),
        .rst_n   ( rst_n      ),
        .rs      ( id_rs      ),
        .rt      ( id_rt      ),
        .rs_data ( id_rs_data ),
        .rt_data ( id_rt_data ),
        .we      ( wb_we      ),
        .wr_addr ( wb_rd      ),
        .wr_data ( wb_data    )
    );

    // Source numbers of the execute instruction are only needed inside the stage
    execute_stage u_execute_stage (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .flush         ( bubble        ),
        .id_ctrl       ( id_ctrl       ),
        .id_rs         ( id_rs         ),
        .id_rt         ( id_rt         ),
        .id_rd         ( id_rd         ),
        .id_rs_data    ( id_rs_data    ),
        .id_rt_data    ( id_rt_data    ),
        .id_imm        ( id_imm        ),
        .id_pc_4       ( id_pc_4       ),
        .mem_fwd_we    ( mem_fwd_we    ),
        .mem_fwd_rd    ( mem_fwd_rd    ),
        .mem_fwd_data  ( mem_fwd_data  ),
        .wb_fwd_we     ( wb_we         ),
        .wb_fwd_rd     ( wb_rd         ),
        .wb_fwd_data   ( wb_data       ),
        .ex_ctrl       ( ex_ctrl       ),
        .ex_rs         (               ),
        .ex_rt         (               ),
        .ex_rd         ( ex_rd         ),
        .ex_result     ( ex_result     ),
        .ex_store_data ( ex_store_data ),
        .branch_taken  ( branch_taken  ),
        .branch_target ( branch_target )
    );

    mem_stage u_mem_stage (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .ex_ctrl       ( ex_ctrl       ),
        .ex_rd         ( ex_rd         ),
        .ex_result     ( ex_result     ),
        .ex_store_data ( ex_store_data ),
        .dmem_addr     ( dmem_addr     ),
        .dmem_wdata    ( dmem_wdata    ),
        .dmem_we       ( dmem_we       ),
        .dmem_re       ( dmem_re       ),
        .dmem_rdata    ( dmem_rdata    ),
        .mem_fwd_we    ( mem_fwd_we    ),
        .mem_fwd_rd    ( mem_fwd_rd    ),
        .mem_fwd_data  ( mem_fwd_data  ),
        .wb_we         ( wb_we         ),
        .wb_rd         ( wb_rd         ),
        .wb_data       ( wb_data       )
    );

    hazard_unit u_hazard_unit (
        .ex_mem_read  ( ex_ctrl.mem_read ),
        .ex_rd        ( ex_rd            ),
        .id_rs        ( id_rs            ),
        .id_rt        ( id_rt            ),
        .branch_taken ( branch_taken     ),
        .stall        ( stall            ),
        .bubble       ( bubble           ),
        .flush        ( flush            )
    );

    // Retired register writes
    assign trace_valid = wb_we;
    assign trace_rd    = wb_rd;
    assign trace_data  = wb_data;

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 5;
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Release shortly after an edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_mips_core.sv ====
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

    localparam int prog_len   = 200;
    localparam int imem_words = 256;
    localparam int dmem_words = 64;
    localparam int max_cycles = 3000;

    logic      clk;
    logic      rst_n;
    word_t     imem_addr;
    word_t     imem_rdata;
    word_t     dmem_addr;
    word_t     dmem_wdata;
    logic      dmem_we;
    logic      dmem_re;
    word_t     dmem_rdata;
    logic      trace_valid;
    reg_addr_t trace_rd;
    word_t     trace_data;

    word_t imem [imem_words];
    word_t dmem [dmem_words];
    word_t model_regs [reg_count];
    word_t model_mem [dmem_words];

    // Expected register writes and stores, oldest first
    reg_addr_t exp_rd [$];
    word_t     exp_wdata [$];
    word_t     exp_st_addr [$];
    word_t     exp_st_data [$];

    int post_reset;

    tb_clock u_tb_clock (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    mips_core u_mips_core (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .imem_addr   ( imem_addr   ),
        .imem_rdata  ( imem_rdata  ),
        .dmem_addr   ( dmem_addr   ),
        .dmem_wdata  ( dmem_wdata  ),
        .dmem_we     ( dmem_we     ),
        .dmem_re     ( dmem_re     ),
        .dmem_rdata  ( dmem_rdata  ),
        .trace_valid ( trace_valid ),
        .trace_rd    ( trace_rd    ),
        .trace_data  ( trace_data  )
    );

    ////////////////////////////////////////
    // Memories
    ////////////////////////////////////////

    // Past the end of the array everything reads as a nop
    assign imem_rdata = (imem_addr < imem_words) ? imem[imem_addr] : nop_instr;

    // Read data only while the core asks for it
    assign dmem_rdata = (dmem_re === 1'b1) ? dmem[dmem_addr[5:0]] : 'x;

    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[5:0]] <= dmem_wdata;
        end
    end

    function automatic word_t fill_word(int idx);
        return 32'h5a00_0000 ^ (idx * 32'h0001_0203);
    endfunction

    function automatic word_t rtype_word(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                         reg_addr_t rd);
        return {op_rtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_equal(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t ns: %s expected 0x%08h, got 0x%08h",
                               $time, name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // Program and reference model
    ////////////////////////////////////////

    task automatic build_program();
        logic [5:0]  functs [6];
        int          kind;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        functs = '{funct_addu, funct_subu, funct_and, funct_or, funct_xor, funct_slt};
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = nop_instr;
        end
        // No memory access in the startup window
        imem[0] = itype_word(op_addiu, 5'd0, 5'd1, 16'($urandom));
        for (int i = 1; i < prog_len; i++) begin
            kind = $urandom % 14;
            // Eight registers only, so dependencies are frequent
            rs   = 5'($urandom % 8);
            rt   = 5'($urandom % 8);
            rd   = 5'($urandom % 8);
            imm  = 16'($urandom);
            case (kind)
                0, 1, 2, 3, 4, 5: imem[i] = rtype_word(functs[kind], rs, rt, rd);
                6:  imem[i] = itype_word(op_addiu, rs, rt, imm);
                7:  imem[i] = itype_word(op_slti, rs, rt, imm);
                8:  imem[i] = itype_word(op_ori, rs, rt, imm);
                9:  imem[i] = itype_word(op_lui, 5'd0, rt, imm);
                10: imem[i] = itype_word(op_lw, 5'd0, rt, 16'(($urandom % 64) * 4));
                11: imem[i] = itype_word(op_sw, 5'd0, rt, 16'(($urandom % 64) * 4));
                12: imem[i] = itype_word(op_beq, rs, rt, 16'(1 + $urandom % 3));
                default: imem[i] = itype_word(op_bne, rs, rt, 16'(1 + $urandom % 3));
            endcase
        end
    endtask

    task automatic record_write(reg_addr_t rd, word_t value);
        if (rd != '0) begin
            model_regs[rd] = value;
            exp_rd.push_back(rd);
            exp_wdata.push_back(value);
        end
    endtask

    // In-order execution, no delay slot
    task automatic run_model();
        word_t       instr;
        word_t       a;
        word_t       b;
        word_t       simm;
        word_t       ea;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        int          pc;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < dmem_words; i++) begin
            model_mem[i] = fill_word(i);
        end
        pc = 0;
        while (pc < prog_len) begin
            instr = imem[pc];
            imm   = instr[15:0];
            rt    = instr[20:16];
            rd    = instr[15:11];
            a     = model_regs[instr[25:21]];
            b     = model_regs[rt];
            simm  = {{16{imm[15]}}, imm};
            ea    = (a + simm) >> 2;
            pc    = pc + 1;
            case (instr[31:26])
                op_rtype: begin
                    case (instr[5:0])
                        funct_addu: record_write(rd, a + b);
                        funct_subu: record_write(rd, a - b);
                        funct_and:  record_write(rd, a & b);
                        funct_or:   record_write(rd, a | b);
                        funct_xor:  record_write(rd, a ^ b);
                        funct_slt:  record_write(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                op_addiu: record_write(rt, a + simm);
                op_slti:  record_write(rt, ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0);
                op_ori:   record_write(rt, a | {16'h0000, imm});
                op_lui:   record_write(rt, {imm, 16'h0000});
                op_lw:    record_write(rt, model_mem[ea[5:0]]);
                op_sw: begin
                    model_mem[ea[5:0]] = b;
                    exp_st_addr.push_back(ea);
                    exp_st_data.push_back(b);
                end
                op_beq: begin
                    if (a == b) begin
                        pc = pc + int'($signed(simm));
                    end
                end
                op_bne: begin
                    if (a != b) begin
                        pc = pc + int'($signed(simm));
                    end
                end
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////
    // Output monitor, mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n || post_reset < 4) begin
            check_equal("trace_valid", trace_valid, 32'd0);
            check_equal("dmem_we", dmem_we, 32'd0);
            check_equal("dmem_re", dmem_re, 32'd0);
        end
        if (rst_n && post_reset == 0) begin
            check_equal("imem_addr", imem_addr, 32'd0);
        end
        if (trace_valid === 1'b1) begin
            if (exp_rd.size() == 0) begin
                fail_run("A register write retired after the last expected one");
            end else begin
                check_equal("trace_rd", trace_rd, exp_rd.pop_front());
                check_equal("trace_data", trace_data, exp_wdata.pop_front());
            end
        end
        if (dmem_we === 1'b1) begin
            if (exp_st_addr.size() == 0) begin
                fail_run("A store reached memory after the last expected one");
            end else begin
                check_equal("dmem_addr", dmem_addr, exp_st_addr.pop_front());
                check_equal("dmem_wdata", dmem_wdata, exp_st_data.pop_front());
            end
        end
        if (rst_n) begin
            post_reset++;
        end
    end

    initial begin
        int cycles;
        post_reset = 0;
        void'($urandom(66));
        build_program();
        run_model();
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = fill_word(i);
        end

        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            fail_run("Reset was never released");
        end

        cycles = 0;
        while ((exp_rd.size() != 0 || exp_st_addr.size() != 0) && cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_rd.size() != 0 || exp_st_addr.size() != 0) begin
            fail_run("The core did not finish the program within the cycle limit");
        end

        // Let fetch run well past the program so nothing is left in flight
        cycles = 0;
        while (imem_addr < prog_len + 8 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (imem_addr < prog_len + 8) begin
            fail_run("The core did not drain after the end of the program");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== sim.f ====
common/mips_pkg.sv
src/execute/alu.sv
src/decode/decoder.sv
src/decode/reg_file.sv
src/fetch_stage.sv
src/execute/execute_stage.sv
src/mem_stage.sv
src/hazard_unit.sv
src/mips_core.sv
tests/tb_clock.sv
tests/tb_mips_core.sv
